// ==== hdl/roberts_macros.svh ====
/* Size and address parameters of the Roberts-cross edge engine.
   Included by the package and by any module that needs the image geometry. */

`ifndef ROBERTS_MACROS_SVH
`define ROBERTS_MACROS_SVH

// input image geometry in pixels
`define EDGE_IMG_W 8
`define EDGE_IMG_H 6

// greyscale pixel width
`define EDGE_PIX_W 8

// frame memory word address width
`define EDGE_ADDR_W 12

// word address of the first result pixel
`define EDGE_OUT_BASE 256

`endif

// ==== hdl/roberts_pkg.sv ====
/* Shared types of the Roberts-cross edge engine.
   Modules refer to them by scoped name, roberts_pkg::pixel_t and so on. */

`include "roberts_macros.svh"

package roberts_pkg;

	// one greyscale pixel
	typedef logic [`EDGE_PIX_W-1:0] pixel_t;

	// word address into the frame memory
	typedef logic [`EDGE_ADDR_W-1:0] frame_addr_t;

	// column index, also the row cache address
	typedef logic [$clog2(`EDGE_IMG_W)-1:0] col_t;

endpackage

// ==== hdl/frame_sequencer.sv ====
/* Control FSM of the edge engine. Walks the image row by row, runs the read
   and write handshakes with the frame memory and strobes the row cache and
   the window buffer. One column is in flight in the datapath at a time. */

`timescale 1ns/10ps

`include "roberts_macros.svh"

module frame_sequencer
(
	input  logic                      clk,
	input  logic                      n_rst,
	input  logic                      start_i,
	input  logic                      rd_valid_i,
	input  roberts_pkg::pixel_t       rd_data_i,
	input  logic                      wr_ack_i,
	input  roberts_pkg::pixel_t       cache_rdata_i,
	input  roberts_pkg::pixel_t       edge_px_i,
	output logic                      rd_req_o,
	output roberts_pkg::frame_addr_t  rd_addr_o,
	output logic                      wr_req_o,
	output roberts_pkg::frame_addr_t  wr_addr_o,
	output roberts_pkg::pixel_t       wr_data_o,
	output logic                      done_o,
	output logic                      cache_wr_o,
	output logic                      cache_rd_o,
	output roberts_pkg::col_t         cache_col_o,
	output roberts_pkg::pixel_t       cache_wdata_o,
	output logic                      shift_o,
	output roberts_pkg::pixel_t       top_px_o,
	output roberts_pkg::pixel_t       bottom_px_o
);

	localparam int ROW_W = $clog2(`EDGE_IMG_H);
	localparam int OUT_W = `EDGE_IMG_W - 1;             // result image width
	localparam roberts_pkg::col_t LAST_COL = roberts_pkg::col_t'(`EDGE_IMG_W - 1);
	localparam logic [ROW_W-1:0]  LAST_ROW = ROW_W'(`EDGE_IMG_H - 1);

	typedef enum logic [3:0]
	{
		idle,
		fill_read,      // row 0: wait for pixel from frame memory
		fill_store,     // row 0: put pixel into the row cache
		col_read,       // later rows: wait for bottom pixel
		cache_read,     // fetch top pixel from the row cache
		shift,          // push new column into the window
		out_write,      // hold the result until acknowledged
		row_next,
		done
	} state_t;

	state_t state_q;
	state_t state_d;

	roberts_pkg::col_t   col_q;
	logic [ROW_W-1:0]    row_q;
	roberts_pkg::pixel_t pix_q;     // latest pixel read from frame memory

	logic last_col;
	logic last_row;

	assign last_col = (col_q == LAST_COL);
	assign last_row = (row_q == LAST_ROW);

	always_comb
	begin : next_state_logic
		state_d = state_q;
		case (state_q)
			idle:
			begin
				if (start_i)
				begin
					state_d = fill_read;
				end
			end
			fill_read:
			begin
				if (rd_valid_i)
				begin
					state_d = fill_store;
				end
			end
			fill_store:
			begin
				state_d = last_col ? row_next : fill_read;
			end
			col_read:
			begin
				if (rd_valid_i)
				begin
					state_d = cache_read;
				end
			end
			cache_read:
			begin
				state_d = shift;
			end
			shift:
			begin
				// column 0 only primes the right half of the window
				state_d = (col_q != '0) ? out_write : col_read;
			end
			out_write:
			begin
				if (wr_ack_i)
				begin
					if (!last_col)
					begin
						state_d = col_read;
					end
					else if (last_row)
					begin
						state_d = done;    // done pulses right after the last write
					end
					else
					begin
						state_d = row_next;
					end
				end
			end
			row_next:
			begin
				state_d = last_row ? done : col_read;
			end
			done:
			begin
				state_d = idle;
			end
			default:
			begin
				state_d = idle;
			end
		endcase
	end

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			state_q <= idle;
			col_q   <= '0;
			row_q   <= '0;
		end
		else
		begin
			state_q <= state_d;
			case (state_q)
				idle:
				begin
					if (start_i)
					begin
						col_q <= '0;
						row_q <= '0;
					end
				end
				fill_store:
				begin
					col_q <= last_col ? '0 : col_q + 1'b1;   // rollover at row end
				end
				shift:
				begin
					if (col_q == '0)
					begin
						col_q <= col_q + 1'b1;
					end
				end
				out_write:
				begin
					if (wr_ack_i)
					begin
						col_q <= last_col ? '0 : col_q + 1'b1;
					end
				end
				row_next:
				begin
					row_q <= row_q + 1'b1;
				end
				default:
				begin
					col_q <= col_q;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_req_o && rd_valid_i)
		begin
			pix_q <= rd_data_i;
		end
	end

	// frame memory handshakes
	assign rd_req_o  = (state_q == fill_read) || (state_q == col_read);
	assign rd_addr_o = roberts_pkg::frame_addr_t'(row_q * `EDGE_IMG_W + col_q);
	assign wr_req_o  = (state_q == out_write);
	assign wr_addr_o = roberts_pkg::frame_addr_t'(`EDGE_OUT_BASE + (row_q - 1'b1) * OUT_W
		+ (col_q - 1'b1));                                 // window top-left is (row-1, col-1)
	assign wr_data_o = edge_px_i;
	assign done_o    = (state_q == done);

	// row cache and window strobes
	assign cache_wr_o    = (state_q == fill_store) || (state_q == shift);
	assign cache_rd_o    = (state_q == cache_read);
	assign cache_col_o   = col_q;
	assign cache_wdata_o = pix_q;     // new pixel becomes next row's top
	assign shift_o       = (state_q == shift);
	assign top_px_o      = cache_rdata_i;
	assign bottom_px_o   = pix_q;

	rd_addr_stable: assert property (@(posedge clk) disable iff (!n_rst)
		rd_req_o && !rd_valid_i |=> rd_req_o && $stable(rd_addr_o));

	wr_data_stable: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && !wr_ack_i |=> wr_req_o && $stable(wr_data_o) && $stable(wr_addr_o));

endmodule

// ==== hdl/row_cache.sv ====
/* One-row pixel memory holding the previous image row.
   Writes land at the clock edge, read data follows one cycle after the strobe. */

`timescale 1ns/10ps

`include "roberts_macros.svh"

module row_cache
(
	input  logic                clk,
	input  logic                cache_wr_i,
	input  logic                cache_rd_i,
	input  roberts_pkg::col_t   col_i,
	input  roberts_pkg::pixel_t wdata_i,
	output roberts_pkg::pixel_t rdata_o
);

	roberts_pkg::pixel_t mem [`EDGE_IMG_W];

	always_ff @(posedge clk)
	begin
		if (cache_wr_i)
		begin
			mem[col_i] <= wdata_i;
		end
	end

	// registered read port
	always_ff @(posedge clk)
	begin
		if (cache_rd_i)
		begin
			rdata_o <= mem[col_i];
		end
	end

	// single port memory, the FSM must never overlap the two
	no_rd_wr_same_cycle: assert property (@(posedge clk)
		!(cache_wr_i && cache_rd_i));

endmodule

// ==== hdl/window_buffer.sv ====
/* 2x2 pixel window and the Roberts-cross operator.
   Each shift moves the right column left and loads a new right column;
   the edge value is combinational from the four registers. */

`timescale 1ns/10ps

`include "roberts_macros.svh"

module window_buffer
(
	input  logic                clk,
	input  logic                n_rst,
	input  logic                shift_i,
	input  roberts_pkg::pixel_t top_i,
	input  roberts_pkg::pixel_t bottom_i,
	output roberts_pkg::pixel_t edge_px_o
);

	roberts_pkg::pixel_t tl_q;   // top left
	roberts_pkg::pixel_t tr_q;   // top right
	roberts_pkg::pixel_t bl_q;   // bottom left
	roberts_pkg::pixel_t br_q;   // bottom right

	roberts_pkg::pixel_t diff_a;
	roberts_pkg::pixel_t diff_b;
	logic [`EDGE_PIX_W:0] sum;   // one carry bit above pixel width

	always_ff @(posedge clk, negedge n_rst)
	begin
		if (n_rst == 1'b0)
		begin
			tl_q <= '0;
			tr_q <= '0;
			bl_q <= '0;
			br_q <= '0;
		end
		else if (shift_i)
		begin
			tl_q <= tr_q;
			bl_q <= br_q;
			tr_q <= top_i;
			br_q <= bottom_i;
		end
	end

	// |tl - br| and |tr - bl|
	assign diff_a = (tl_q > br_q) ? tl_q - br_q : br_q - tl_q;
	assign diff_b = (tr_q > bl_q) ? tr_q - bl_q : bl_q - tr_q;

	assign sum = {1'b0, diff_a} + {1'b0, diff_b};

	// clip to the brightest pixel value
	assign edge_px_o = sum[`EDGE_PIX_W] ? '1 : sum[`EDGE_PIX_W-1:0];

	// a shift never loads an unwritten cache entry or an unread pixel
	shift_inputs_known: assert property (@(posedge clk) disable iff (!n_rst)
		shift_i |-> !$isunknown({top_i, bottom_i}));

endmodule

// ==== hdl/roberts_engine.sv ====
/* Top level of the Roberts-cross edge engine. Connects the control FSM,
   the row cache and the window buffer to the frame memory ports. */

`timescale 1ns/10ps

module roberts_engine
(
	input  logic                      clk,
	input  logic                      n_rst,
	input  logic                      start_i,
	input  logic                      rd_valid_i,
	input  roberts_pkg::pixel_t       rd_data_i,
	input  logic                      wr_ack_i,
	output logic                      rd_req_o,
	output roberts_pkg::frame_addr_t  rd_addr_o,
	output logic                      wr_req_o,
	output roberts_pkg::frame_addr_t  wr_addr_o,
	output roberts_pkg::pixel_t       wr_data_o,
	output logic                      done_o
);

	logic                cache_wr;
	logic                cache_rd;
	roberts_pkg::col_t   cache_col;
	roberts_pkg::pixel_t cache_wdata;
	roberts_pkg::pixel_t cache_rdata;   // previous row pixel, one cycle late
	logic                shift;
	roberts_pkg::pixel_t top_px;
	roberts_pkg::pixel_t bottom_px;
	roberts_pkg::pixel_t edge_px;

	frame_sequencer seq_i
	(
		.clk           (clk),
		.n_rst         (n_rst),
		.start_i       (start_i),
		.rd_valid_i    (rd_valid_i),
		.rd_data_i     (rd_data_i),
		.wr_ack_i      (wr_ack_i),
		.cache_rdata_i (cache_rdata),
		.edge_px_i     (edge_px),
		.rd_req_o      (rd_req_o),
		.rd_addr_o     (rd_addr_o),
		.wr_req_o      (wr_req_o),
		.wr_addr_o     (wr_addr_o),
		.wr_data_o     (wr_data_o),
		.done_o        (done_o),
		.cache_wr_o    (cache_wr),
		.cache_rd_o    (cache_rd),
		.cache_col_o   (cache_col),
		.cache_wdata_o (cache_wdata),
		.shift_o       (shift),
		.top_px_o      (top_px),
		.bottom_px_o   (bottom_px)
	);

	row_cache cache_i
	(
		.clk        (clk),
		.cache_wr_i (cache_wr),
		.cache_rd_i (cache_rd),
		.col_i      (cache_col),
		.wdata_i    (cache_wdata),
		.rdata_o    (cache_rdata)
	);

	window_buffer window_i
	(
		.clk       (clk),
		.n_rst     (n_rst),
		.shift_i   (shift),
		.top_i     (top_px),
		.bottom_i  (bottom_px),
		.edge_px_o (edge_px)
	);

endmodule

// ==== verif/frame_memory_model.sv ====
/* Frame memory model for the edge engine testbench. Answers each read after a
   random latency and acknowledges each write after a random delay. */

`timescale 1ns/10ps

`include "roberts_macros.svh"

module frame_memory_model
#(
	parameter int SEED       = 83,
	parameter int RD_LAT_MAX = 5,
	parameter int WR_DLY_MAX = 4
)
(
	input  logic                     clk,
	input  logic                     n_rst,
	input  logic                     rd_req_i,
	input  roberts_pkg::frame_addr_t rd_addr_i,
	output logic                     rd_valid_o,
	output roberts_pkg::pixel_t      rd_data_o,
	input  logic                     wr_req_i,
	input  roberts_pkg::frame_addr_t wr_addr_i,
	input  roberts_pkg::pixel_t      wr_data_i,
	output logic                     wr_ack_o
);

	localparam logic [31:0] LCG_MUL = 32'd1103515245;
	localparam logic [31:0] LCG_INC = 32'd12345;

	roberts_pkg::pixel_t mem [2**`EDGE_ADDR_W];   // image loaded by the testbench

	logic [31:0]         lcg_state  = SEED;
	logic                rd_valid   = 1'b0;
	roberts_pkg::pixel_t rd_data    = '0;
	logic                wr_ack     = 1'b0;
	logic                rd_pending = 1'b0;      // a latency has been drawn
	logic                wr_pending = 1'b0;
	int                  rd_wait    = 0;
	int                  wr_wait    = 0;

	function automatic logic [14:0] next_random();
		lcg_state = lcg_state * LCG_MUL + LCG_INC;
		return lcg_state[30:16];
	endfunction

	// responses change on the falling edge, the DUT samples them on the rising one
	always @(negedge clk)
	begin
		rd_valid = 1'b0;   // a valid or ack cycle is always taken at the next edge
		wr_ack   = 1'b0;
		if (!n_rst)
		begin
			rd_pending = 1'b0;
			wr_pending = 1'b0;
		end
		else
		begin
			if (rd_req_i)
			begin
				if (!rd_pending)
				begin
					rd_pending = 1'b1;
					rd_wait    = next_random() % (RD_LAT_MAX + 1);
				end
				if (rd_wait == 0)
				begin
					rd_valid   = 1'b1;
					rd_data    = mem[rd_addr_i];
					rd_pending = 1'b0;
				end
				else
				begin
					rd_wait = rd_wait - 1;
				end
			end
			if (wr_req_i)
			begin
				if (!wr_pending)
				begin
					wr_pending = 1'b1;
					wr_wait    = next_random() % (WR_DLY_MAX + 1);
				end
				if (wr_wait == 0)
				begin
					wr_ack         = 1'b1;
					mem[wr_addr_i] = wr_data_i;
					wr_pending     = 1'b0;
				end
				else
				begin
					wr_wait = wr_wait - 1;
				end
			end
		end
	end

	assign rd_valid_o = rd_valid;
	assign rd_data_o  = rd_data;
	assign wr_ack_o   = wr_ack;

endmodule

// ==== verif/roberts_engine_tb.sv ====
/* Testbench of the Roberts-cross edge engine. Runs three frames through a
   random latency frame memory; concurrent assertions compare every read and
   write with a reference computed from the testbench's own image copy. */

`timescale 1ns/10ps

`include "roberts_macros.svh"

module roberts_engine_tb;

	localparam int  IMG_W      = `EDGE_IMG_W;
	localparam int  IMG_H      = `EDGE_IMG_H;
	localparam int  IN_PIX     = IMG_W * IMG_H;
	localparam int  OUT_W      = IMG_W - 1;
	localparam int  OUT_PIX    = (IMG_W - 1) * (IMG_H - 1);
	localparam int  OUT_BASE   = `EDGE_OUT_BASE;
	localparam int  PIX_MAX    = 2**`EDGE_PIX_W - 1;
	localparam time CLK_PERIOD = 100;
	localparam int  RESET_CYC  = 4;
	localparam int  IDLE_CYC   = 10;
	localparam int  NUM_FRAMES = 3;
	localparam int  RD_LAT_MAX = 5;
	localparam int  WR_DLY_MAX = 4;
	localparam int  LCG_SEED   = 83;
	localparam logic [31:0] LCG_MUL = 32'd1103515245;
	localparam logic [31:0] LCG_INC = 32'd12345;
	// worst case: every read and every write at its longest wait, plus FSM overhead
	localparam int  FRAME_MAX  = IN_PIX * (RD_LAT_MAX + 3) + OUT_PIX * (WR_DLY_MAX + 1)
		+ IMG_H + 4;
	localparam int  TIMEOUT_CYC = 2 * (NUM_FRAMES * FRAME_MAX + RESET_CYC + IDLE_CYC);

	logic                     clk;
	logic                     n_rst;
	logic                     start_i;
	logic                     rd_valid_i;
	roberts_pkg::pixel_t      rd_data_i;
	logic                     wr_ack_i;
	logic                     rd_req_o;
	roberts_pkg::frame_addr_t rd_addr_o;
	logic                     wr_req_o;
	roberts_pkg::frame_addr_t wr_addr_o;
	roberts_pkg::pixel_t      wr_data_o;
	logic                     done_o;

	roberts_pkg::pixel_t img [IMG_H][IMG_W];   // reference copy of the input image
	logic [31:0] lcg_state    = LCG_SEED;
	logic        frame_active = 1'b0;
	int          rd_count     = 0;            // reads accepted in this frame
	int          wr_count     = 0;
	int          cycle_count  = 0;
	int          error_count  = 0;
	int          test_err_base = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;
	string       test_name    = "reset_idle";

	roberts_engine roberts_engine_i
	(
		.clk        (clk),
		.n_rst      (n_rst),
		.start_i    (start_i),
		.rd_valid_i (rd_valid_i),
		.rd_data_i  (rd_data_i),
		.wr_ack_i   (wr_ack_i),
		.rd_req_o   (rd_req_o),
		.rd_addr_o  (rd_addr_o),
		.wr_req_o   (wr_req_o),
		.wr_addr_o  (wr_addr_o),
		.wr_data_o  (wr_data_o),
		.done_o     (done_o)
	);

	frame_memory_model #(.SEED(LCG_SEED), .RD_LAT_MAX(RD_LAT_MAX), .WR_DLY_MAX(WR_DLY_MAX))
	mem_model_i
	(
		.clk        (clk),
		.n_rst      (n_rst),
		.rd_req_i   (rd_req_o),
		.rd_addr_i  (rd_addr_o),
		.rd_valid_o (rd_valid_i),
		.rd_data_o  (rd_data_i),
		.wr_req_i   (wr_req_o),
		.wr_addr_i  (wr_addr_o),
		.wr_data_i  (wr_data_o),
		.wr_ack_o   (wr_ack_i)
	);

	function automatic logic [14:0] next_random();
		lcg_state = lcg_state * LCG_MUL + LCG_INC;
		return lcg_state[30:16];
	endfunction

	// row-major input address of the k-th read
	function automatic int in_addr(input int k);
		return (k / IMG_W) * IMG_W + (k % IMG_W);
	endfunction

	// k-th result belongs to the window with bottom-right pixel (r, c)
	function automatic int out_addr(input int k);
		int r;
		int c;
		r = k / OUT_W + 1;
		c = k % OUT_W + 1;
		return OUT_BASE + (r - 1) * OUT_W + (c - 1);
	endfunction

	function automatic int roberts_ref(input int k);
		int r;
		int c;
		int d1;
		int d2;
		r  = k / OUT_W + 1;
		c  = k % OUT_W + 1;
		d1 = int'(img[r-1][c-1]) - int'(img[r][c]);
		d2 = int'(img[r-1][c]) - int'(img[r][c-1]);
		d1 = (d1 < 0) ? -d1 : d1;
		d2 = (d2 < 0) ? -d2 : d2;
		return (d1 + d2 > PIX_MAX) ? PIX_MAX : d1 + d2;
	endfunction

	task automatic report_value(input string what, input int expected, input int actual);
		error_count = error_count + 1;
		$display("[ERROR] %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
	endtask

	task automatic report_failure(input string what);
		error_count = error_count + 1;
		$display("[ERROR] %s: %s", test_name, what);
	endtask

	task automatic begin_test(input string name);
		test_name     = name;
		test_err_base = error_count;
	endtask

	task automatic finish_test();
		int errs;
		errs      = error_count - test_err_base;
		tests_run = tests_run + 1;
		if (errs == 0)
		begin
			$display("test %s passed", test_name);
		end
		else
		begin
			tests_failed = tests_failed + 1;
			$display("test %s failed with %0d errors", test_name, errs);
		end
	endtask

	task automatic load_image();
		for (int r = 0; r < IMG_H; r++)
		begin
			for (int c = 0; c < IMG_W; c++)
			begin
				mem_model_i.mem[r * IMG_W + c] = img[r][c];
			end
		end
	endtask

	task automatic fill_random();
		for (int r = 0; r < IMG_H; r++)
		begin
			for (int c = 0; c < IMG_W; c++)
			begin
				img[r][c] = roberts_pkg::pixel_t'(next_random());
			end
		end
		load_image();
	endtask

	// cells one column wide and two rows tall give both saturated and zero windows
	task automatic fill_checkerboard();
		for (int r = 0; r < IMG_H; r++)
		begin
			for (int c = 0; c < IMG_W; c++)
			begin
				img[r][c] = ((c + r / 2) % 2 == 1) ? roberts_pkg::pixel_t'(PIX_MAX) : '0;
			end
		end
		load_image();
	endtask

	task automatic run_frame(input string name);
		begin_test(name);
		@(negedge clk);
		frame_active = 1'b1;
		start_i      = 1'b1;
		@(negedge clk);
		start_i = 1'b0;
		while (done_o !== 1'b1)
		begin
			@(negedge clk);
		end
		@(negedge clk);
		frame_active = 1'b0;
		finish_test();
	endtask

	always @(posedge clk)
	begin
		if (start_i)
		begin
			rd_count <= 0;
			wr_count <= 0;
		end
		else
		begin
			if (rd_req_o && rd_valid_i)
			begin
				rd_count <= rd_count + 1;
			end
			if (wr_req_o && wr_ack_i)
			begin
				wr_count <= wr_count + 1;
			end
		end
	end

	idle_quiet: assert property (@(posedge clk) disable iff (!n_rst)
		!frame_active |-> !rd_req_o && !wr_req_o && !done_o)
		else report_failure("request or done seen while no frame was started");

	rd_in_image: assert property (@(posedge clk) disable iff (!n_rst)
		rd_req_o |-> rd_addr_o < IN_PIX)
		else report_failure("read request outside the input image");

	rd_order: assert property (@(posedge clk) disable iff (!n_rst)
		rd_req_o && rd_valid_i |-> rd_addr_o == in_addr(rd_count))
		else report_value("read address", in_addr($sampled(rd_count)), $sampled(rd_addr_o));

	wr_too_many: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && wr_ack_i |-> wr_count < OUT_PIX)
		else report_failure("more writes than result pixels");

	wr_address: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && wr_ack_i |-> wr_addr_o == out_addr(wr_count))
		else report_value("write address", out_addr($sampled(wr_count)), $sampled(wr_addr_o));

	wr_value: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && wr_ack_i |-> wr_data_o == roberts_ref(wr_count))
		else report_value("write data", roberts_ref($sampled(wr_count)), $sampled(wr_data_o));

	rd_hold: assert property (@(posedge clk) disable iff (!n_rst)
		rd_req_o && !rd_valid_i |=> rd_req_o && $stable(rd_addr_o))
		else report_failure("read request dropped or its address moved while waiting");

	wr_hold: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && !wr_ack_i |=> wr_req_o && $stable(wr_addr_o) && $stable(wr_data_o))
		else report_failure("write request dropped or changed while waiting");

	done_after_last: assert property (@(posedge clk) disable iff (!n_rst)
		wr_req_o && wr_ack_i && wr_count == OUT_PIX - 1 |=> done_o)
		else report_failure("done did not follow the last write");

	done_writes: assert property (@(posedge clk) disable iff (!n_rst)
		done_o |-> wr_count == OUT_PIX)
		else report_value("write count", OUT_PIX, $sampled(wr_count));

	done_reads: assert property (@(posedge clk) disable iff (!n_rst)
		done_o |-> rd_count == IN_PIX)
		else report_value("read count", IN_PIX, $sampled(rd_count));

	done_pulse: assert property (@(posedge clk) disable iff (!n_rst)
		done_o |=> !done_o)
		else report_failure("done stayed high for more than one cycle");

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	initial
	begin
		while (cycle_count < TIMEOUT_CYC)
		begin
			@(posedge clk);
			cycle_count = cycle_count + 1;
		end
		$display("timeout after %0d cycles, test %s never saw done", TIMEOUT_CYC, test_name);
		$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		n_rst   = 1'b0;
		start_i = 1'b0;
		begin_test("reset_idle");
		repeat (RESET_CYC) @(negedge clk);
		n_rst = 1'b1;
		repeat (IDLE_CYC) @(negedge clk);   // outputs must stay quiet without a start
		finish_test();
		fill_random();
		run_frame("random_frame");
		fill_random();
		run_frame("second_frame");
		fill_checkerboard();
		run_frame("checkerboard");
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
		if (error_count == 0)
		begin
			$display("ALL CHECKS PASSED");
		end
		else
		begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== roberts_engine.f ====
+incdir+hdl
hdl/roberts_pkg.sv
hdl/frame_sequencer.sv
hdl/row_cache.sv
hdl/window_buffer.sv
hdl/roberts_engine.sv
verif/frame_memory_model.sv
verif/roberts_engine_tb.sv

// ==== Bender.yml ====
package:
  name: roberts_engine

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/roberts_pkg.sv
      - hdl/frame_sequencer.sv
      - hdl/row_cache.sv
      - hdl/window_buffer.sv
      - hdl/roberts_engine.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/frame_memory_model.sv
      - verif/roberts_engine_tb.sv
